//--- design/pin_io_pkg.sv
package pin_io_pkg;

  // number of pin channels in the subsystem.
  localparam int num_channels = 4;

  // width of a channel number inside the arbiter.
  localparam int chan_idx_w = $clog2(num_channels);

  // block number that selects the time base instead of a channel.
  localparam logic [7:0] global_block = 8'hff;

  // register offsets, taken from addr[7:0].
  localparam logic [7:0] addr_global_cmd  = 8'd0;  // time base run control.
  localparam logic [7:0] addr_nco_incr    = 8'd1;  // oscillator phase increment.
  localparam logic [7:0] addr_end_time    = 8'd2;
  localparam logic [7:0] addr_local_cmd   = 8'd3;
  localparam logic [7:0] addr_sample_rate = 8'd4;  // interval in clock cycles.
  localparam logic [7:0] addr_sample_reg  = 8'd5;
  localparam logic [7:0] addr_sample_cnt  = 8'd7;
  localparam logic [7:0] addr_status      = 8'd8;
  localparam logic [7:0] addr_last_data   = 8'd9;

  // command codes written to addr_local_cmd.
  localparam logic [31:0] cmd_const        = 32'd2;
  localparam logic [31:0] cmd_square_wave  = 32'd3;
  localparam logic [31:0] cmd_input_stream = 32'd4;
  localparam logic [31:0] cmd_reset        = 32'd5;

  // one-hot channel state, reported in the status register.
  typedef enum logic [3:0] {
    st_idle         = 4'b0001,
    st_const        = 4'b0010,
    st_input_stream = 4'b0100,
    st_square       = 4'b1000
  } chan_state_t;

endpackage

//--- design/chan_bus_if.sv
`timescale 1ns/1ps

// sample request link between one channel and the arbiter.
interface chan_bus_if;

  logic        req;    // held high until the arbiter grants it.
  logic        grant;  // one cycle wide.
  logic [15:0] count;
  logic        level;

  modport channel (
    output req,
    output count,
    output level,
    input  grant
  );

  modport arbiter (
    input  req,
    input  count,
    input  level,
    output grant
  );

endinterface

//--- design/time_base.sv
`timescale 1ns/1ps

module time_base (
  input  logic        clk,
  input  logic        reset,
  input  logic        wr,
  input  logic        rd,
  input  logic [15:0] addr,
  input  logic [31:0] wr_data,
  output logic [31:0] current_time,
  output logic [15:0] rd_word
);
  import pin_io_pkg::*;

  logic run;
  logic cmd_hit;

  assign cmd_hit = (addr[15:8] == global_block) && (addr[7:0] == addr_global_cmd);

  // a start write moves time to 1 right away, so channels see it on the next cycle.
  always_ff @(posedge clk) begin
    if (reset) begin
      run          <= 1'b0;
      current_time <= '0;
    end else if (wr && cmd_hit) begin
      run          <= wr_data[0];
      current_time <= wr_data[0] ? current_time + 32'd1 : '0;  // stop also clears time.
    end else if (run) begin
      current_time <= current_time + 32'd1;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) rd_word <= '0;
    else if (rd && cmd_hit) rd_word <= {15'b0, run};
    else rd_word <= '0;  // zero when not addressed so the top can OR the words.
  end

endmodule

//--- design/pin_channel.sv
`timescale 1ns/1ps

module pin_channel #(
  parameter int channel_index = 0
) (
  input  logic        clk,
  input  logic        reset,
  input  logic        wr,
  input  logic        rd,
  input  logic [15:0] addr,
  input  logic [31:0] wr_data,
  input  logic [31:0] current_time,
  input  logic        pin_in,
  output logic        pin_out,
  output logic        pin_oe,
  output logic [15:0] rd_word,
  chan_bus_if.channel smp
);
  import pin_io_pkg::*;

  logic        chan_sel;
  logic        chan_wr;
  logic        chan_rd;
  logic [31:0] command;
  logic [31:0] nco_incr;
  logic [31:0] end_time;
  logic [31:0] sample_rate;
  logic [15:0] last_data;
  chan_state_t state;
  chan_state_t state_next;
  logic        time_running;
  logic        stop;
  logic        clr_cmd;
  logic [31:0] phase_acc;
  logic [31:0] rate_cnt;
  logic [31:0] rate_limit;
  logic        capture;
  logic        sample_reg;
  logic [15:0] sample_cnt;
  logic        req;
  logic        overrun;

  assign chan_sel = (addr[15:8] == 8'(channel_index));
  assign chan_wr  = wr && chan_sel;
  assign chan_rd  = rd && chan_sel;

  assign time_running = (current_time != '0);

  // An end time of zero means run until a reset command arrives.
  assign stop = (command == cmd_reset) ||
                ((end_time != '0) && (current_time >= end_time));

  // In idle any pending command is consumed once time runs.
  // While running only a reset command is consumed, and others wait.
  assign clr_cmd = (state == st_idle) ? (time_running && (command != '0))
                                      : (command == cmd_reset);

  always_ff @(posedge clk) begin
    if (reset) begin
      command <= '0;
    end else if (chan_wr && (addr[7:0] == addr_local_cmd)) begin
      command <= wr_data;  // a new write wins over the clear.
    end else if (clr_cmd) begin
      command <= '0;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      nco_incr    <= '0;
      end_time    <= '0;
      sample_rate <= '0;
    end else if (chan_wr) begin
      case (addr[7:0])
        addr_nco_incr:    nco_incr    <= wr_data;
        addr_end_time:    end_time    <= wr_data;
        addr_sample_rate: sample_rate <= wr_data;
        default: ;
      endcase
    end
  end

  // Kept for bus debug, any write to this channel lands here.
  always_ff @(posedge clk) begin
    if (chan_wr) last_data <= wr_data[15:0];
  end

  always_comb begin
    state_next = state;
    case (state)
      st_idle: begin
        if (time_running) begin
          if (command == cmd_const) state_next = st_const;
          else if (command == cmd_square_wave) state_next = st_square;
          else if (command == cmd_input_stream) state_next = st_input_stream;
        end
      end
      st_const, st_square, st_input_stream: begin
        if (stop) state_next = st_idle;
      end
      default: state_next = st_idle;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) state <= st_idle;
    else state <= state_next;
  end

  // The accumulator looks at the next state so that pin_out is high
  // in the very first cycle of st_const.
  always_ff @(posedge clk) begin
    if (reset) phase_acc <= '0;
    else if (state_next == st_const) phase_acc <= '1;
    else phase_acc <= phase_acc + nco_incr;
  end

  assign pin_out = phase_acc[31];  // output frequency is about f_clk * nco_incr / 2^32.
  assign pin_oe  = (state == st_const) || (state == st_square);

  assign rate_limit = (sample_rate == '0) ? 32'd1 : sample_rate;
  assign capture    = (state == st_input_stream) && !stop &&
                      (rate_cnt >= rate_limit - 32'd1);

  always_ff @(posedge clk) begin
    if (reset) rate_cnt <= '0;
    else if ((state != st_input_stream) || capture) rate_cnt <= '0;
    else rate_cnt <= rate_cnt + 32'd1;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      sample_reg <= 1'b0;
      sample_cnt <= '0;
      req        <= 1'b0;
      overrun    <= 1'b0;
    end else if (capture) begin
      sample_reg <= pin_in;
      sample_cnt <= sample_cnt + 16'd1;
      req        <= 1'b1;
      // The older capture is lost when it has not been granted yet.
      if (req && !smp.grant) overrun <= 1'b1;
    end else if (smp.grant) begin
      req <= 1'b0;
    end
  end

  assign smp.req   = req;
  assign smp.count = sample_cnt;
  assign smp.level = sample_reg;

  always_ff @(posedge clk) begin
    if (reset) begin
      rd_word <= '0;
    end else if (chan_rd) begin
      case (addr[7:0])
        addr_sample_reg: rd_word <= {15'b0, sample_reg};
        addr_sample_cnt: rd_word <= sample_cnt;
        addr_status:     rd_word <= {11'b0, overrun, state};
        addr_last_data:  rd_word <= last_data;
        default:         rd_word <= '0;
      endcase
    end else begin
      rd_word <= '0;
    end
  end

endmodule

//--- design/sample_arbiter.sv
`timescale 1ns/1ps

module sample_arbiter (
  input  logic        clk,
  input  logic        reset,
  chan_bus_if.arbiter chans [pin_io_pkg::num_channels],
  output logic        sample_valid,
  output logic [31:0] sample_data
);
  import pin_io_pkg::*;

  logic [num_channels-1:0] req_vec;
  logic [num_channels-1:0] grant_vec;
  logic [15:0]             count_vec [num_channels];
  logic [num_channels-1:0] level_vec;
  logic [chan_idx_w-1:0]   last_ptr;
  logic [chan_idx_w-1:0]   grant_idx;
  logic                    any_req;

  // Interface arrays need constant indices, so each link is flattened here.
  for (genvar i = 0; i < num_channels; i++) begin : g_link
    assign req_vec[i]     = chans[i].req;
    assign count_vec[i]   = chans[i].count;
    assign level_vec[i]   = chans[i].level;
    assign chans[i].grant = grant_vec[i];
  end

  assign any_req = |req_vec;

  // Scan from the farthest offset down, so the nearest requester after
  // the last grant is the one left in grant_idx.
  always_comb begin
    int idx;
    grant_idx = last_ptr;
    for (int off = num_channels; off >= 1; off--) begin
      idx = (int'(last_ptr) + off) % num_channels;
      if (req_vec[idx]) grant_idx = chan_idx_w'(idx);
    end
  end

  always_comb begin
    grant_vec = '0;
    if (any_req) grant_vec[grant_idx] = 1'b1;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      last_ptr     <= chan_idx_w'(num_channels - 1);  // channel 0 goes first.
      sample_valid <= 1'b0;
    end else begin
      sample_valid <= any_req;
      if (any_req) last_ptr <= grant_idx;
    end
  end

  // The record is channel, count and level, as the channel held them at grant.
  always_ff @(posedge clk) begin
    if (any_req) begin
      sample_data <= {8'(grant_idx), count_vec[grant_idx], 7'b0, level_vec[grant_idx]};
    end
  end

endmodule

//--- design/pin_io_top.sv
`timescale 1ns/1ps

module pin_io_top (
  input  logic                                clk,
  input  logic                                reset,
  input  logic                                wr,
  input  logic                                rd,
  input  logic [15:0]                         addr,
  input  logic [31:0]                         wr_data,
  output logic [15:0]                         rd_data,
  input  logic [pin_io_pkg::num_channels-1:0] pin_in,
  output logic [pin_io_pkg::num_channels-1:0] pin_out,
  output logic [pin_io_pkg::num_channels-1:0] pin_oe,
  output logic                                sample_valid,
  output logic [31:0]                         sample_data
);
  import pin_io_pkg::*;

  logic [31:0] current_time;
  logic [15:0] time_rd_word;
  logic [15:0] chan_rd_word [num_channels];

  chan_bus_if smp_if [num_channels] ();

  time_base u_time_base (
    .clk          (clk),
    .reset        (reset),
    .wr           (wr),
    .rd           (rd),
    .addr         (addr),
    .wr_data      (wr_data),
    .current_time (current_time),
    .rd_word      (time_rd_word)
  );

  for (genvar ch = 0; ch < num_channels; ch++) begin : g_chan
    pin_channel #(
      .channel_index (ch)
    ) u_chan (
      .clk          (clk),
      .reset        (reset),
      .wr           (wr),
      .rd           (rd),
      .addr         (addr),
      .wr_data      (wr_data),
      .current_time (current_time),
      .pin_in       (pin_in[ch]),
      .pin_out      (pin_out[ch]),
      .pin_oe       (pin_oe[ch]),
      .rd_word      (chan_rd_word[ch]),
      .smp          (smp_if[ch])
    );
  end

  sample_arbiter u_arbiter (
    .clk          (clk),
    .reset        (reset),
    .chans        (smp_if),
    .sample_valid (sample_valid),
    .sample_data  (sample_data)
  );

  // Only the addressed block returns a nonzero word, so a plain OR merges them.
  always_comb begin
    rd_data = time_rd_word;
    for (int ch = 0; ch < num_channels; ch++) begin
      rd_data = rd_data | chan_rd_word[ch];
    end
  end

endmodule

//--- dv/pin_io_properties.sv
`timescale 1ns/1ps

// rules on the round-robin sample arbiter.
module pin_io_properties (
  input logic                                clk,
  input logic                                reset,
  input logic [pin_io_pkg::num_channels-1:0] req_vec,
  input logic [pin_io_pkg::num_channels-1:0] grant_vec,
  input logic                                sample_valid
);

  int fail_cnt = 0;  // number of failed assertions so far.

  // only one channel can win the output port in a cycle.
  one_grant: assert property (@(posedge clk) disable iff (reset) $onehot0(grant_vec))
    else begin
      $error("more than one grant in one cycle");
      fail_cnt++;
    end

  granted_req: assert property (@(posedge clk) disable iff (reset)
    (grant_vec & ~req_vec) == '0)
    else begin
      $error("grant given to a channel without a request");
      fail_cnt++;
    end

  // the record leaves the arbiter one cycle after the grant.
  valid_after_grant: assert property (@(posedge clk) disable iff (reset)
    (|grant_vec) |=> sample_valid)
    else begin
      $error("sample_valid missing one cycle after a grant");
      fail_cnt++;
    end

  valid_needs_grant: assert property (@(posedge clk) disable iff (reset)
    sample_valid |-> $past(|grant_vec))
    else begin
      $error("sample_valid without a grant in the cycle before");
      fail_cnt++;
    end

endmodule

bind sample_arbiter pin_io_properties u_props (
  .clk          (clk),
  .reset        (reset),
  .req_vec      (req_vec),
  .grant_vec    (grant_vec),
  .sample_valid (sample_valid)
);

//--- dv/pin_io_tb.sv
`timescale 1ns/1ps

module pin_io_tb;
  import pin_io_pkg::*;

  logic                    clk;
  logic                    reset;
  logic                    wr;
  logic                    rd;
  logic [15:0]             addr;
  logic [31:0]             wr_data;
  logic [15:0]             rd_data;
  logic [num_channels-1:0] pin_in;
  logic [num_channels-1:0] pin_out;
  logic [num_channels-1:0] pin_oe;
  logic                    sample_valid;
  logic [31:0]             sample_data;

  integer      seed = 32'hea9;
  int          cycle_cnt = 0;
  logic [31:0] sample_q [$];      // sample records in arrival order.
  int          sample_cyc_q [$];  // cycle number of each record.

  pin_io_top dut0 (
    .clk          (clk),
    .reset        (reset),
    .wr           (wr),
    .rd           (rd),
    .addr         (addr),
    .wr_data      (wr_data),
    .rd_data      (rd_data),
    .pin_in       (pin_in),
    .pin_out      (pin_out),
    .pin_oe       (pin_oe),
    .sample_valid (sample_valid),
    .sample_data  (sample_data)
  );

  always #20 clk = ~clk;

  always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

  // the falling edge sits halfway between drive and capture.
  always @(negedge clk) begin
    if (sample_valid) begin
      sample_q.push_back(sample_data);
      sample_cyc_q.push_back(cycle_cnt);
    end
    check_true("arbiter_properties", dut0.u_arbiter.u_props.fail_cnt == 0,
               "a bound arbiter assertion failed");
  end

  task automatic stop_on_error();
    $display("Simulation finished: FAIL");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic check_value(string test, string what, logic [31:0] expected,
                             logic [31:0] actual);
    assert (actual == expected) else begin
      $display("** Error %s (%s): expected %0h, actual %0h", test, what, expected, actual);
      stop_on_error();
    end
  endtask

  task automatic check_true(string test, bit cond, string what);
    assert (cond) else begin
      $display("%s: %s", test, what);
      stop_on_error();
    end
  endtask

  task automatic step_clock();
    @(posedge clk);
    #2;
  endtask

  function automatic logic [15:0] reg_addr(int ch, logic [7:0] offset);
    return {8'(ch), offset};
  endfunction

  task automatic bus_write(logic [15:0] a, logic [31:0] d);
    step_clock();
    wr      = 1'b1;
    addr    = a;
    wr_data = d;
    step_clock();  // the write lands on this edge.
    wr = 1'b0;
  endtask

  task automatic bus_read(logic [15:0] a, output logic [15:0] d);
    step_clock();
    rd   = 1'b1;
    addr = a;
    step_clock();
    rd = 1'b0;
    d  = rd_data;  // registered read word, valid in the cycle after rd.
  endtask

  task automatic clear_samples();
    sample_q.delete();
    sample_cyc_q.delete();
  endtask

  task automatic wait_samples(string test, int n, int limit);
    int waited;
    waited = 0;
    while (sample_q.size() < n && waited < limit) begin
      step_clock();
      waited++;
    end
    check_true(test, sample_q.size() >= n, "timed out waiting for sample records");
  endtask

  task automatic test_register_access();
    logic [31:0] word;
    logic [15:0] rword;
    logic [7:0]  offsets [3];
    offsets = '{addr_nco_incr, addr_end_time, addr_sample_rate};
    check_value("register_access", "pin_oe after reset", 0, pin_oe);
    check_value("register_access", "sample_valid after reset", 0, sample_valid);
    check_value("register_access", "rd_data after reset", 0, rd_data);
    for (int ch = 0; ch < num_channels; ch++) begin
      for (int k = 0; k < 3; k++) begin
        word = $random(seed);
        bus_write(reg_addr(ch, offsets[k]), word);
        bus_read(reg_addr(ch, addr_last_data), rword);
        check_value("register_access", "last_data", word[15:0], rword);
      end
      bus_read(reg_addr(ch, addr_status), rword);
      check_value("register_access", "status state", st_idle, rword[3:0]);
      check_value("register_access", "status overrun", 0, rword[4]);
      bus_write(reg_addr(ch, addr_end_time), 32'd0);  // run until reset command.
    end
    bus_read({8'h10, addr_last_data}, rword);
    check_value("register_access", "unaddressed block", 0, rword);
  endtask

  task automatic test_const_output();
    int  end_t;
    int  t_now;
    int  waited;
    bit  rose;
    bit  dropped;
    end_t = 20;
    bus_write(reg_addr(0, addr_end_time), end_t);
    bus_write(reg_addr(0, addr_local_cmd), cmd_const);
    repeat (4) begin
      step_clock();
      check_value("const_output", "pin_oe while time stopped", 0, pin_oe[0]);
    end
    bus_write({global_block, addr_global_cmd}, 32'd1);
    t_now   = 1;  // time reads 1 right after the start write.
    rose    = 0;
    dropped = 0;
    waited  = 0;
    while (!dropped && waited < 100) begin
      step_clock();
      t_now++;
      waited++;
      if (pin_oe[0]) begin
        rose = 1;
        check_value("const_output", "pin_out", 1, pin_out[0]);
      end else if (rose) begin
        dropped = 1;
      end
    end
    check_true("const_output", rose, "pin_oe never rose after time started");
    check_true("const_output", dropped, "pin_oe did not drop after end_time");
    check_true("const_output", t_now >= end_t && t_now <= end_t + 2,
               $sformatf("pin_oe dropped at time %0d, end_time was %0d", t_now, end_t));
    bus_write(reg_addr(0, addr_end_time), 32'd0);
  endtask

  task automatic test_square_wave();
    int waited;
    bit prev;
    bit found;
    bus_write(reg_addr(1, addr_nco_incr), 32'h4000_0000);  // a quarter turn per cycle.
    bus_write(reg_addr(1, addr_end_time), 32'd0);
    bus_write(reg_addr(1, addr_local_cmd), cmd_square_wave);
    waited = 0;
    while (!pin_oe[1] && waited < 10) begin
      step_clock();
      waited++;
    end
    check_true("square_wave", pin_oe[1], "pin_oe stayed low after the square wave command");
    found  = 0;
    waited = 0;
    prev   = pin_out[1];
    while (!found && waited < 10) begin
      step_clock();
      waited++;
      if (!prev && pin_out[1]) found = 1;
      prev = pin_out[1];
    end
    check_true("square_wave", found, "no rising edge seen on pin_out");
    for (int i = 0; i < 32; i++) begin
      if (i > 0) step_clock();
      check_value("square_wave", $sformatf("pin_out cycle %0d", i), (i % 4) < 2, pin_out[1]);
      check_value("square_wave", "pin_oe", 1, pin_oe[1]);
    end
    bus_write(reg_addr(1, addr_local_cmd), cmd_reset);
    waited = 0;
    while (pin_oe[1] && waited < 2) begin
      step_clock();
      waited++;
    end
    check_value("square_wave", "pin_oe after cmd_reset", 0, pin_oe[1]);
  endtask

  task automatic test_input_stream();
    int          rate_r;
    logic        level;
    logic [31:0] rec;
    logic [31:0] prev_rec;
    rate_r = 5;
    step_clock();
    pin_in = 4'($random(seed));
    level  = pin_in[2];
    bus_write(reg_addr(2, addr_sample_rate), rate_r);
    clear_samples();
    bus_write(reg_addr(2, addr_local_cmd), cmd_input_stream);
    wait_samples("input_stream", 6, 100);
    for (int i = 0; i < 6; i++) begin
      rec = sample_q[i];
      check_value("input_stream", "channel", 2, rec[31:24]);
      check_value("input_stream", "level", level, rec[0]);
      check_value("input_stream", "unused bits", 0, rec[7:1]);
      if (i == 0) begin
        check_value("input_stream", "first count", 1, rec[23:8]);
      end else begin
        check_value("input_stream", "count step", prev_rec[23:8] + 16'd1, rec[23:8]);
        check_value("input_stream", "spacing", rate_r, sample_cyc_q[i] - sample_cyc_q[i-1]);
      end
      prev_rec = rec;
    end
    bus_write(reg_addr(2, addr_local_cmd), cmd_reset);
    repeat (6) step_clock();
  endtask

  task automatic test_shared_arbitration();
    int          mask;
    logic [31:0] rec;
    logic [15:0] rword;
    step_clock();
    pin_in = 4'($random(seed));
    for (int ch = 0; ch < num_channels; ch++) bus_write(reg_addr(ch, addr_sample_rate), 32'd1);
    for (int ch = 0; ch < num_channels; ch++) begin
      bus_write(reg_addr(ch, addr_local_cmd), cmd_input_stream);
    end
    repeat (8) step_clock();  // let every channel reach its steady request.
    clear_samples();
    wait_samples("shared_arbitration", 16, 50);
    for (int i = 0; i + 4 <= 16; i++) begin
      mask = 0;
      for (int j = 0; j < 4; j++) begin
        rec  = sample_q[i+j];
        mask = mask | (1 << rec[31:24]);
      end
      check_value("shared_arbitration", $sformatf("window %0d", i), 32'hf, mask);
    end
    for (int i = 0; i < 16; i++) begin
      rec = sample_q[i];
      check_value("shared_arbitration", "level", pin_in[rec[25:24]], rec[0]);
    end
    for (int ch = 0; ch < num_channels; ch++) begin
      bus_read(reg_addr(ch, addr_status), rword);
      check_value("shared_arbitration", "overrun", 1, rword[4]);
      check_value("shared_arbitration", "state", st_input_stream, rword[3:0]);
    end
  endtask

  task automatic test_stop_on_reset();
    logic [31:0] rec;
    logic [15:0] rword;
    bus_write(reg_addr(3, addr_local_cmd), cmd_reset);
    repeat (5) step_clock();  // a record granted just before the stop may still leave.
    clear_samples();
    repeat (20) step_clock();
    check_true("stop_on_reset", sample_q.size() > 0, "the other channels stopped streaming");
    for (int i = 0; i < sample_q.size(); i++) begin
      rec = sample_q[i];
      check_true("stop_on_reset", rec[31:24] != 8'd3,
                 "channel 3 still produced samples after cmd_reset");
    end
    bus_read(reg_addr(3, addr_status), rword);
    check_value("stop_on_reset", "state", st_idle, rword[3:0]);
  endtask

  initial begin
    clk     = 1'b0;
    reset   = 1'b1;
    wr      = 1'b0;
    rd      = 1'b0;
    addr    = '0;
    wr_data = '0;
    pin_in  = '0;
    repeat (10) @(posedge clk);
    #2;
    reset = 1'b0;
    test_register_access();
    test_const_output();
    test_square_wave();
    test_input_stream();
    test_shared_arbitration();
    test_stop_on_reset();
    if (dut0.u_arbiter.u_props.fail_cnt == 0) begin
      $display("Simulation finished: PASS");
      $finish;
    end else begin
      $display("arbiter_properties: a bound arbiter assertion failed");
      stop_on_error();
    end
  end

endmodule

//--- pin_io_top.f
design/pin_io_pkg.sv
design/chan_bus_if.sv
design/time_base.sv
design/pin_channel.sv
design/sample_arbiter.sv
design/pin_io_top.sv
dv/pin_io_properties.sv
dv/pin_io_tb.sv
